//--- sdram_rd.f
hw/sdram_rd_pkg.sv
hw/sdram_rd_ctrl.sv
hw/sdram_rd_addr.sv
hw/sdram_rd_capture.sv
hw/sdram_refresh_timer.sv
hw/sdram_rd_fifo.sv
hw/sdram_rd_top.sv
verification/sdram_model.sv
verification/sdram_rd_tb.sv

//--- Bender.yml
package:
  name: sdram_rd

sources:
  - hw/sdram_rd_pkg.sv
  - hw/sdram_rd_ctrl.sv
  - hw/sdram_rd_addr.sv
  - hw/sdram_rd_capture.sv
  - hw/sdram_refresh_timer.sv
  - hw/sdram_rd_fifo.sv
  - hw/sdram_rd_top.sv
  - target: test
    files:
      - verification/sdram_model.sv
      - verification/sdram_rd_tb.sv

//--- verification/sdram_rd_tb.sv
module sdram_rd_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int T_RCD = 2;
	localparam int T_CAS = 2;
	localparam int T_RP = 2;
	localparam int T_RFC = 7;
	localparam int REFRESH_INTERVAL = 390;
	localparam int FIFO_DEPTH = 16;
	localparam int N_REQ = 7;

	logic clk = 1'b0;
	logic rst;
	logic start;
	logic [sdram_rd_pkg::ADDR_W-1:0] read_address;
	logic [sdram_rd_pkg::COUNT_W-1:0] read_count;
	logic busy;
	logic finished;
	sdram_rd_pkg::sdram_cmd_e command;
	logic [sdram_rd_pkg::SDRAM_ADDR_W-1:0] addr;
	logic [sdram_rd_pkg::BANK_W-1:0] bank;
	logic [sdram_rd_pkg::DQ_W-1:0] data_in;
	logic rd_en;
	logic [sdram_rd_pkg::WORD_W-1:0] rd_data;
	logic empty;
	logic fault;

	// request table with address, word count, throttled consumer and refresh expected
	logic [21:0] req_addr [N_REQ];
	int req_count [N_REQ];
	bit req_throttle [N_REQ];
	bit req_need_ar [N_REQ];

	int cycle_cnt = 0;
	int cycle_limit = 2000;
	int cmd_count;
	int ar_count;
	sdram_rd_pkg::sdram_cmd_e last_cmd = sdram_rd_pkg::CMD_NOP;
	logic [15:0] lfsr;

	always #10 clk = ~clk;

	sdram_rd_top #(
		.T_RCD(T_RCD),
		.T_CAS(T_CAS),
		.T_RP(T_RP),
		.T_RFC(T_RFC),
		.REFRESH_INTERVAL(REFRESH_INTERVAL),
		.FIFO_DEPTH(FIFO_DEPTH)
	) DUT (
		.clk(clk),
		.rst(rst),
		.start(start),
		.read_address(read_address),
		.read_count(read_count),
		.busy(busy),
		.finished(finished),
		.command(command),
		.addr(addr),
		.bank(bank),
		.data_in(data_in),
		.rd_en(rd_en),
		.rd_data(rd_data),
		.empty(empty)
	);

	sdram_model #(
		.T_RCD(T_RCD),
		.T_CAS(T_CAS),
		.T_RP(T_RP),
		.T_RFC(T_RFC)
	) u_model (
		.clk(clk),
		.rst(rst),
		.command(command),
		.addr(addr),
		.bank(bank),
		.data_in(data_in),
		.fault(fault)
	);

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("ERR %0t ns %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	// taps 16, 14, 13, 11 for a maximal-length sequence
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// device beat is the low half of row * 512 + column with the bank folded into bits 15:14
	function automatic logic [15:0] beat_value(input logic [1:0] b, input logic [11:0] r,
		input logic [8:0] c);
		logic [31:0] lin;
		lin = 32'(r) * 512 + 32'(c);
		return lin[15:0] ^ {b, 14'b0};
	endfunction

	// word column w maps to device columns 2w and 2w+1
	function automatic logic [31:0] expected_word(input logic [21:0] a);
		logic [8:0] c;
		c = {a[7:0], 1'b0};
		return {beat_value(a[21:20], a[19:8], c), beat_value(a[21:20], a[19:8], c + 9'd1)};
	endfunction

	// command bus monitor and run length guard
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			fail_run("run did not complete within the cycle limit");
		end
		if (!rst && command != sdram_rd_pkg::CMD_NOP) begin
			cmd_count = cmd_count + 1;
			if (command == sdram_rd_pkg::CMD_AR) begin
				ar_count = ar_count + 1;
				if (last_cmd != sdram_rd_pkg::CMD_PRE) begin
					fail_run("auto-refresh was not preceded by a precharge");
				end
			end
			last_cmd = command;
		end
	end

	always @(posedge fault) begin
		fail_run("SDRAM model saw an illegal command sequence");
	end

	task automatic run_request(input int idx);
		logic [21:0] waddr;
		int got;
		int fin_count;
		waddr = req_addr[idx];
		got = 0;
		fin_count = 0;
		@(posedge clk);
		#2;
		cmd_count = 0;
		ar_count = 0;
		start = 1'b1;
		read_address = req_addr[idx];
		read_count = sdram_rd_pkg::COUNT_W'(req_count[idx]);
		rd_en = 1'b0;
		do begin
			@(posedge clk);
			#2;
			start = 1'b0;
			if (finished) begin
				fin_count++;
			end
			// busy from the start until finished and never for an empty request
			check_value("busy", busy, (req_count[idx] != 0) && (fin_count == 0));
			if (req_throttle[idx]) begin
				lfsr = lfsr_next(lfsr);
				rd_en = lfsr[0];
			end else begin
				rd_en = 1'b1;
			end
			// head word leaves at the next edge
			if (rd_en && !empty) begin
				check_value("rd_data", rd_data, expected_word(waddr));
				waddr = waddr + 1'b1;
				got++;
			end
		end while (fin_count == 0 || got < req_count[idx]);
		@(posedge clk);
		#2;
		rd_en = 1'b0;
		if (finished) begin
			fin_count++;
		end
		check_value("finished pulses", fin_count, 1);
		check_value("empty", empty, 1'b1);
		if (req_count[idx] == 0) begin
			check_value("commands issued", cmd_count, 0);
		end
		if (req_need_ar[idx]) begin
			check_value("refresh seen", ar_count > 0, 1'b1);
		end
	endtask

	initial begin
		int total;
		req_addr = '{22'h00050A, 22'h200900, 22'h1003FA, 22'h2FFFFF, 22'h3FFFFE,
			22'h006400, 22'h100780};
		req_count = '{8, 0, 12, 8, 6, 600, 400};
		req_throttle = '{0, 0, 0, 0, 0, 1, 0};
		req_need_ar = '{0, 0, 0, 0, 0, 1, 1};
		total = 0;
		for (int i = 0; i < N_REQ; i++) begin
			total += req_count[i];
		end
		cycle_limit = 40 * total + 2000;
		rst = 1'b1;
		start = 1'b0;
		read_address = '0;
		read_count = '0;
		rd_en = 1'b0;
		lfsr = 16'd63;
		cmd_count = 0;
		ar_count = 0;
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;
		// idle outputs before any request
		repeat (3) begin
			@(posedge clk);
			#2;
			check_value("command", command, sdram_rd_pkg::CMD_NOP);
			check_value("busy", busy, 1'b0);
			check_value("finished", finished, 1'b0);
			check_value("empty", empty, 1'b1);
		end
		for (int i = 0; i < N_REQ; i++) begin
			run_request(i);
		end
		@(posedge clk);
		$display("TEST OK");
		$finish;
	end

endmodule

//--- verification/sdram_model.sv
module sdram_model #(
	parameter int T_RCD = 2,
	parameter int T_CAS = 2,
	parameter int T_RP = 2,
	parameter int T_RFC = 7
) (
	input logic clk,
	input logic rst,
	input sdram_rd_pkg::sdram_cmd_e command,
	input logic [sdram_rd_pkg::SDRAM_ADDR_W-1:0] addr,
	input logic [sdram_rd_pkg::BANK_W-1:0] bank,
	output logic [sdram_rd_pkg::DQ_W-1:0] data_in,
	output logic fault
);
	timeunit 1ns;
	timeprecision 1ps;

	// per-bank open row state
	logic [3:0] open_bank;
	logic [sdram_rd_pkg::ROW_W-1:0] open_row [4];
	// edge index of the last ACT, PRE and AR
	int act_at [4];
	int pre_at;
	int ar_at;
	int cyc = 0;
	// slot k of the beat schedule drives the cycle after edge k mod 8
	logic [sdram_rd_pkg::DQ_W-1:0] sched_d [8];
	logic [7:0] sched_v;

	initial fault = 1'b0;

	// beat value from bank, row and device column
	function automatic logic [15:0] beat(input logic [1:0] b, input logic [11:0] r,
		input logic [8:0] c);
		logic [31:0] lin;
		lin = 32'(r) * 512 + 32'(c);
		return lin[15:0] ^ {b, 14'b0};
	endfunction

	task automatic violation(input string msg);
		$display("SDRAM model at %0t ns: %s", $time, msg);
		fault = 1'b1;
	endtask

	always @(posedge clk) begin
		cyc = cyc + 1;
		if (rst) begin
			open_bank = '0;
			sched_v = '0;
			pre_at = -100;
			ar_at = -100;
			for (int b = 0; b < 4; b++) begin
				act_at[b] = -100;
			end
		end else begin
			// nothing but NOP while a refresh runs
			if (command != sdram_rd_pkg::CMD_NOP && cyc - ar_at < T_RFC + 1) begin
				violation("command issued before the refresh cycle time ran out");
			end
			case (command)
				sdram_rd_pkg::CMD_ACT: begin
					if (open_bank[bank]) begin
						violation("ACT to a bank that already has an open row");
					end
					if (cyc - pre_at < T_RP + 1) begin
						violation("ACT too soon after a precharge");
					end
					open_bank[bank] = 1'b1;
					open_row[bank] = addr;
					act_at[bank] = cyc;
				end
				sdram_rd_pkg::CMD_READ: begin
					if (!open_bank[bank]) begin
						violation("READ to a bank with no open row");
					end else if (cyc - act_at[bank] < T_RCD + 1) begin
						violation("READ too soon after ACT");
					end
					// burst of two with the high half first
					sched_d[(cyc + T_CAS - 1) % 8] = beat(bank, open_row[bank], addr[8:0]);
					sched_v[(cyc + T_CAS - 1) % 8] = 1'b1;
					sched_d[(cyc + T_CAS) % 8] = beat(bank, open_row[bank], addr[8:0] + 9'd1);
					sched_v[(cyc + T_CAS) % 8] = 1'b1;
				end
				sdram_rd_pkg::CMD_PRE: begin
					// A10 closes every bank
					if (addr[10]) begin
						open_bank = '0;
					end else begin
						open_bank[bank] = 1'b0;
					end
					pre_at = cyc;
				end
				sdram_rd_pkg::CMD_AR: begin
					if (|open_bank) begin
						violation("auto-refresh with a row still open");
					end
					if (cyc - pre_at < T_RP + 1) begin
						violation("auto-refresh too soon after a precharge");
					end
					ar_at = cyc;
				end
				default: begin
				end
			endcase
		end
		// bus floats when no beat is due
		data_in <= sched_v[cyc % 8] ? sched_d[cyc % 8] : 'x;
		sched_v[cyc % 8] = 1'b0;
	end

endmodule

//--- hw/sdram_rd_top.sv
module sdram_rd_top #(
	parameter int T_RCD = 2,
	parameter int T_CAS = 2,
	parameter int T_RP = 2,
	parameter int T_RFC = 7,
	parameter int REFRESH_INTERVAL = 390,
	parameter int FIFO_DEPTH = 16
) (
	input logic clk,
	input logic rst,
	// request
	input logic start,
	input logic [sdram_rd_pkg::ADDR_W-1:0] read_address,
	input logic [sdram_rd_pkg::COUNT_W-1:0] read_count,
	output logic busy,
	output logic finished,
	// SDRAM pins
	output sdram_rd_pkg::sdram_cmd_e command,
	output logic [sdram_rd_pkg::SDRAM_ADDR_W-1:0] addr,
	output logic [sdram_rd_pkg::BANK_W-1:0] bank,
	input logic [sdram_rd_pkg::DQ_W-1:0] data_in,
	// consumer side
	input logic rd_en,
	output logic [sdram_rd_pkg::WORD_W-1:0] rd_data,
	output logic empty
);

	localparam int INF_W = $clog2(T_CAS + 4);
	localparam int FREE_W = $clog2(FIFO_DEPTH + 1);

	logic load;
	logic step_col;
	logic step_row;
	logic row_end;
	logic last;
	logic [sdram_rd_pkg::BANK_W-1:0] cur_bank;
	logic [sdram_rd_pkg::ROW_W-1:0] cur_row;
	logic [sdram_rd_pkg::COL_W-1:0] cur_col;
	logic read_issued;
	logic [INF_W-1:0] inflight;
	logic drained;
	logic wr_en;
	logic [sdram_rd_pkg::WORD_W-1:0] wr_data;
	logic [FREE_W-1:0] free;
	logic refresh_req;
	logic refresh_ack;

	// command sequencing
	sdram_rd_ctrl #(
		.T_RCD(T_RCD),
		.T_CAS(T_CAS),
		.T_RP(T_RP),
		.T_RFC(T_RFC),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_ctrl (
		.clk(clk),
		.rst(rst),
		.start(start),
		.read_count(read_count),
		.busy(busy),
		.finished(finished),
		.command(command),
		.addr(addr),
		.bank(bank),
		.load(load),
		.step_col(step_col),
		.step_row(step_row),
		.row_end(row_end),
		.last(last),
		.cur_bank(cur_bank),
		.cur_row(cur_row),
		.cur_col(cur_col),
		.read_issued(read_issued),
		.inflight(inflight),
		.drained(drained),
		.free(free),
		.refresh_req(refresh_req),
		.refresh_ack(refresh_ack)
	);

	// bank, row, column and word count
	sdram_rd_addr u_addr (
		.clk(clk),
		.rst(rst),
		.load(load),
		.step_col(step_col),
		.step_row(step_row),
		.read_address(read_address),
		.read_count(read_count),
		.cur_bank(cur_bank),
		.cur_row(cur_row),
		.cur_col(cur_col),
		.row_end(row_end),
		.last(last)
	);

	// beat packing into FIFO words
	sdram_rd_capture #(
		.T_CAS(T_CAS)
	) u_capture (
		.clk(clk),
		.rst(rst),
		.read_issued(read_issued),
		.data_in(data_in),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.inflight(inflight),
		.drained(drained)
	);

	sdram_refresh_timer #(
		.REFRESH_INTERVAL(REFRESH_INTERVAL)
	) u_refresh (
		.clk(clk),
		.rst(rst),
		.refresh_ack(refresh_ack),
		.refresh_req(refresh_req)
	);

	sdram_rd_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.clk(clk),
		.rst(rst),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.rd_en(rd_en),
		.rd_data(rd_data),
		.empty(empty),
		.free(free)
	);

endmodule

//--- hw/sdram_rd_fifo.sv
module sdram_rd_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input logic clk,
	input logic rst,
	input logic wr_en,
	input logic [sdram_rd_pkg::WORD_W-1:0] wr_data,
	input logic rd_en,
	output logic [sdram_rd_pkg::WORD_W-1:0] rd_data,
	output logic empty,
	output logic [$clog2(FIFO_DEPTH+1)-1:0] free
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic [sdram_rd_pkg::WORD_W-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_wr;
	logic do_rd;

	// a write into a full buffer is dropped
	assign do_wr = wr_en && (count != CNT_W'(FIFO_DEPTH));

	// pops on an empty buffer are ignored
	assign do_rd = rd_en && !empty;

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// pointers wrap on their own since depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
		end
	end

	// head word is visible without a read strobe
	assign rd_data = mem[rd_ptr];
	assign empty = (count == '0);
	assign free = CNT_W'(FIFO_DEPTH) - count;

endmodule

//--- hw/sdram_refresh_timer.sv
module sdram_refresh_timer #(
	parameter int REFRESH_INTERVAL = 390
) (
	input logic clk,
	input logic rst,
	input logic refresh_ack,
	output logic refresh_req
);

	localparam int CNT_W = $clog2(REFRESH_INTERVAL + 1);

	logic [CNT_W-1:0] count;

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
			refresh_req <= 1'b0;
		end else begin
			// request holds until the controller issues AR
			if (refresh_ack) begin
				refresh_req <= 1'b0;
			end
			// a fresh expiry wins over a same-cycle ack
			if (count == CNT_W'(REFRESH_INTERVAL - 1)) begin
				count <= '0;
				refresh_req <= 1'b1;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

//--- hw/sdram_rd_capture.sv
module sdram_rd_capture #(
	parameter int T_CAS = 2
) (
	input logic clk,
	input logic rst,
	input logic read_issued,
	input logic [sdram_rd_pkg::DQ_W-1:0] data_in,
	output logic wr_en,
	output logic [sdram_rd_pkg::WORD_W-1:0] wr_data,
	output logic [$clog2(T_CAS+4)-1:0] inflight,
	output logic drained
);

	localparam int INF_W = $clog2(T_CAS + 4);

	// bit k marks a READ issued k+1 cycles ago
	logic [T_CAS:0] token;
	logic [sdram_rd_pkg::DQ_W-1:0] hi_beat;
	logic [INF_W-1:0] inflight_nxt;

	always_ff @(posedge clk) begin
		if (rst) begin
			token <= '0;
			wr_en <= 1'b0;
		end else begin
			token <= {token[T_CAS-1:0], read_issued};
			// low beat arrives one cycle after the high beat
			wr_en <= token[T_CAS];
		end
	end

	always_ff @(posedge clk) begin
		// high half comes first on the bus
		if (token[T_CAS-1]) begin
			hi_beat <= data_in;
		end
		if (token[T_CAS]) begin
			wr_data <= {hi_beat, data_in};
		end
	end

	// up on a READ, down when its word enters the FIFO
	assign inflight_nxt = inflight + INF_W'(read_issued) - INF_W'(wr_en);

	always_ff @(posedge clk) begin
		if (rst) begin
			inflight <= '0;
		end else begin
			inflight <= inflight_nxt;
		end
	end

	// already high in the cycle of the last FIFO write
	assign drained = (inflight_nxt == '0);

endmodule

//--- hw/sdram_rd_addr.sv
module sdram_rd_addr (
	input logic clk,
	input logic rst,
	input logic load,
	input logic step_col,
	input logic step_row,
	input logic [sdram_rd_pkg::ADDR_W-1:0] read_address,
	input logic [sdram_rd_pkg::COUNT_W-1:0] read_count,
	output logic [sdram_rd_pkg::BANK_W-1:0] cur_bank,
	output logic [sdram_rd_pkg::ROW_W-1:0] cur_row,
	output logic [sdram_rd_pkg::COL_W-1:0] cur_col,
	output logic row_end,
	output logic last
);

	// words still to be read, including the current one
	logic [sdram_rd_pkg::COUNT_W-1:0] remaining;

	always_ff @(posedge clk) begin
		if (rst) begin
			remaining <= '0;
		end else if (load) begin
			remaining <= read_count;
		end else if (step_col) begin
			remaining <= remaining - 1'b1;
		end
	end

	// bank, row and column of the next READ
	always_ff @(posedge clk) begin
		if (load) begin
			cur_bank <= read_address[sdram_rd_pkg::ADDR_W-1 -: sdram_rd_pkg::BANK_W];
			cur_row <= read_address[sdram_rd_pkg::COL_W +: sdram_rd_pkg::ROW_W];
			cur_col <= read_address[sdram_rd_pkg::COL_W-1:0];
		end else begin
			// column wraps to zero past 255
			if (step_col) begin
				cur_col <= cur_col + 1'b1;
			end
			if (step_row) begin
				cur_row <= cur_row + 1'b1;
				// last row of a bank carries into the next bank
				if (&cur_row) begin
					cur_bank <= cur_bank + 1'b1;
				end
			end
		end
	end

	// final column of the open row
	assign row_end = &cur_col;

	// one word left
	assign last = (remaining == sdram_rd_pkg::COUNT_W'(1));

endmodule

//--- hw/sdram_rd_ctrl.sv
module sdram_rd_ctrl #(
	parameter int T_RCD = 2,
	parameter int T_CAS = 2,
	parameter int T_RP = 2,
	parameter int T_RFC = 7,
	parameter int FIFO_DEPTH = 16
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [sdram_rd_pkg::COUNT_W-1:0] read_count,
	output logic busy,
	output logic finished,
	output sdram_rd_pkg::sdram_cmd_e command,
	output logic [sdram_rd_pkg::SDRAM_ADDR_W-1:0] addr,
	output logic [sdram_rd_pkg::BANK_W-1:0] bank,
	output logic load,
	output logic step_col,
	output logic step_row,
	input logic row_end,
	input logic last,
	input logic [sdram_rd_pkg::BANK_W-1:0] cur_bank,
	input logic [sdram_rd_pkg::ROW_W-1:0] cur_row,
	input logic [sdram_rd_pkg::COL_W-1:0] cur_col,
	output logic read_issued,
	input logic [$clog2(T_CAS+4)-1:0] inflight,
	input logic drained,
	input logic [$clog2(FIFO_DEPTH+1)-1:0] free,
	input logic refresh_req,
	output logic refresh_ack
);

	// longest command gap sets the delay counter width
	localparam int T_MAX_A = (T_RCD > T_RP) ? T_RCD : T_RP;
	localparam int T_MAX = (T_RFC > T_MAX_A) ? T_RFC : T_MAX_A;
	localparam int DLY_W = $clog2(T_MAX + 2);

	// A10 high selects all banks on a precharge
	localparam logic [sdram_rd_pkg::SDRAM_ADDR_W-1:0] A10_ALL = 'h400;

	sdram_rd_pkg::rd_state_e state;
	logic [DLY_W-1:0] delay;
	logic last_sent;
	logic can_issue;
	logic issue_read;

	// nonzero delay forces NOP on the bus
	assign can_issue = (delay == '0);

	// next READ needs a clear gap, no refresh waiting and room for every word in flight
	assign issue_read = (state == sdram_rd_pkg::ST_READ) && can_issue && !refresh_req &&
		(free > inflight);

	// a request with words loads the address datapath
	assign load = ((state == sdram_rd_pkg::ST_IDLE) || (state == sdram_rd_pkg::ST_FINISH)) &&
		start && (read_count != '0);

	// column moves with each READ
	assign step_col = issue_read;

	// row moves when the row-end precharge goes out
	assign step_row = (state == sdram_rd_pkg::ST_PRECHARGE) && can_issue;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= sdram_rd_pkg::ST_IDLE;
			command <= sdram_rd_pkg::CMD_NOP;
			delay <= '0;
			busy <= 1'b0;
			finished <= 1'b0;
			read_issued <= 1'b0;
			refresh_ack <= 1'b0;
			last_sent <= 1'b0;
		end else begin
			// strobes and command default to idle values
			command <= sdram_rd_pkg::CMD_NOP;
			finished <= 1'b0;
			read_issued <= 1'b0;
			refresh_ack <= 1'b0;
			if (!can_issue) begin
				delay <= delay - 1'b1;
			end
			case (state)
				sdram_rd_pkg::ST_IDLE, sdram_rd_pkg::ST_FINISH: begin
					// a start is taken even while the closing precharge times out
					state <= sdram_rd_pkg::ST_IDLE;
					if (start) begin
						if (read_count == '0) begin
							finished <= 1'b1;
							state <= sdram_rd_pkg::ST_FINISH;
						end else begin
							busy <= 1'b1;
							last_sent <= 1'b0;
							state <= sdram_rd_pkg::ST_ACTIVATE;
						end
					end
				end
				sdram_rd_pkg::ST_ACTIVATE: begin
					if (can_issue) begin
						command <= sdram_rd_pkg::CMD_ACT;
						addr <= cur_row;
						bank <= cur_bank;
						delay <= DLY_W'(T_RCD);
						state <= sdram_rd_pkg::ST_READ;
					end
				end
				sdram_rd_pkg::ST_READ: begin
					if (can_issue && refresh_req) begin
						state <= sdram_rd_pkg::ST_DRAIN;
					end else if (issue_read) begin
						command <= sdram_rd_pkg::CMD_READ;
						// device column is the word column doubled, A10 low
						addr <= {3'b000, cur_col, 1'b0};
						bank <= cur_bank;
						read_issued <= 1'b1;
						// one NOP between READs for the second beat
						delay <= DLY_W'(1);
						if (last) begin
							last_sent <= 1'b1;
							state <= sdram_rd_pkg::ST_DRAIN;
						end else if (row_end) begin
							state <= sdram_rd_pkg::ST_PRECHARGE;
						end
					end
				end
				sdram_rd_pkg::ST_DRAIN: begin
					// row closes only once every word has reached the FIFO
					if (can_issue && drained) begin
						command <= sdram_rd_pkg::CMD_PRE;
						addr <= A10_ALL;
						bank <= cur_bank;
						delay <= DLY_W'(T_RP);
						if (last_sent) begin
							finished <= 1'b1;
							busy <= 1'b0;
							state <= sdram_rd_pkg::ST_FINISH;
						end else begin
							state <= sdram_rd_pkg::ST_REFRESH;
						end
					end
				end
				sdram_rd_pkg::ST_PRECHARGE: begin
					// row end, then open the following row
					if (can_issue) begin
						command <= sdram_rd_pkg::CMD_PRE;
						addr <= A10_ALL;
						bank <= cur_bank;
						delay <= DLY_W'(T_RP);
						state <= sdram_rd_pkg::ST_ACTIVATE;
					end
				end
				sdram_rd_pkg::ST_REFRESH: begin
					// afterwards the same row is opened again
					if (can_issue) begin
						command <= sdram_rd_pkg::CMD_AR;
						refresh_ack <= 1'b1;
						delay <= DLY_W'(T_RFC);
						state <= sdram_rd_pkg::ST_ACTIVATE;
					end
				end
				default: begin
					state <= sdram_rd_pkg::ST_IDLE;
				end
			endcase
		end
	end

endmodule

//--- hw/sdram_rd_pkg.sv
package sdram_rd_pkg;

	// request address holds bank on top, then row and the 32-bit word column
	localparam int BANK_W = 2;
	localparam int ROW_W = 12;
	localparam int COL_W = 8;
	localparam int ADDR_W = BANK_W + ROW_W + COL_W;

	// word count carried with a request
	localparam int COUNT_W = 24;

	// device pins
	localparam int SDRAM_ADDR_W = 12;
	localparam int DQ_W = 16;

	// one FIFO word holds two device beats
	localparam int WORD_W = 2 * DQ_W;

	// command bits are {ras_n, cas_n, we_n}
	typedef enum logic [2:0] {
		CMD_NOP = 3'b111,
		CMD_ACT = 3'b011,
		CMD_READ = 3'b101,
		CMD_PRE = 3'b010,
		CMD_AR = 3'b001
	} sdram_cmd_e;

	// controller FSM states
	typedef enum logic [3:0] {
		ST_IDLE = 4'd0,
		ST_ACTIVATE = 4'd1,
		ST_READ = 4'd2,
		// wait for in-flight words before a precharge
		ST_DRAIN = 4'd3,
		ST_PRECHARGE = 4'd4,
		ST_REFRESH = 4'd5,
		// cycle that carries the finished pulse
		ST_FINISH = 4'd6
	} rd_state_e;

endpackage
